//--- lsu_patterns.txt
// columns are id we size sext use_off base offset wdata exp_rdata exp_err back_to_back
// every field is hex and size is 0 for word, 1 for half and 2 for byte
1 1 0 0 0 00000100 00000000 deadbeef 00000000 0 0
1 0 0 0 1 000000f0 00000010 00000000 deadbeef 0 0
2 1 2 0 0 00000200 00000000 00000011 00000000 0 0
2 1 2 0 0 00000201 00000000 ffffff22 00000000 0 0
2 1 2 0 0 00000202 00000000 00000033 00000000 0 0
2 1 2 0 0 00000203 00000000 12345644 00000000 0 0
2 0 0 0 0 00000200 00000000 00000000 44332211 0 0
2 1 1 0 0 00000204 00000000 aaaa1234 00000000 0 0
2 1 1 0 1 00000200 00000006 ffffbeef 00000000 0 0
2 0 0 0 0 00000204 00000000 00000000 beef1234 0 0
3 0 2 0 0 00000207 00000000 00000000 000000be 0 0
3 0 2 1 0 00000207 00000000 00000000 ffffffbe 0 0
3 0 1 0 0 00000206 00000000 00000000 0000beef 0 0
3 0 1 1 0 00000205 00000000 00000000 ffffef12 0 0
3 0 2 1 0 00000203 00000000 00000000 00000044 0 0
4 1 0 0 0 00000301 00000000 a1b2c3d4 00000000 0 0
4 0 0 0 0 00000301 00000000 00000000 a1b2c3d4 0 0
4 0 0 0 0 00000300 00000000 00000000 b2c3d400 0 0
4 0 0 0 0 00000304 00000000 00000000 000000a1 0 0
4 1 0 0 0 0000030a 00000000 11223344 00000000 0 0
4 0 0 0 0 0000030a 00000000 00000000 11223344 0 0
4 1 0 0 0 00000313 00000000 55667788 00000000 0 0
4 0 0 0 0 00000313 00000000 00000000 55667788 0 0
4 0 0 0 0 00000310 00000000 00000000 88000000 0 0
4 1 1 0 0 0000031b 00000000 00009abc 00000000 0 0
4 0 1 1 0 0000031b 00000000 00000000 ffff9abc 0 0
4 0 0 0 0 0000031c 00000000 00000000 0000009a 0 0
5 1 0 0 0 00000400 00000000 cafef00d 00000000 1 0
5 0 0 0 0 00000400 00000000 00000000 00000000 1 0
5 1 0 0 1 00000200 00000300 12345678 00000000 1 0
5 0 0 0 0 000003fe 00000000 00000000 00000000 1 0
5 0 0 0 0 00000000 00000000 00000000 00000000 0 0
5 0 0 0 0 00000100 00000000 00000000 deadbeef 0 0
6 1 0 0 0 00000020 00000000 01020304 00000000 0 0
6 1 0 0 0 00000026 00000000 a5a6a7a8 00000000 0 1
6 0 0 0 0 00000020 00000000 00000000 01020304 0 1
6 0 0 0 0 00000026 00000000 00000000 a5a6a7a8 0 1
6 0 2 1 0 00000027 00000000 00000000 ffffffa7 0 1
6 0 0 0 0 00000024 00000000 00000000 a7a80000 0 1
6 0 0 0 0 00000028 00000000 00000000 0000a5a6 0 1

//--- flist.f
+incdir+.
lsu_pkg.sv
lsu_agu.sv
lsu_req_ctrl.sv
lsu_rdata_align.sv
lsu_data_mem.sv
lsu_top.sv
tb_lsu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  ?= Verification passed

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu;
  import lsu_pkg::*;

  localparam int nf        = 11;  // hex fields per pattern line
  localparam int max_lines = 64;
  localparam int half_per  = 4;   // 8 ns clock

  localparam int col_id    = 0;
  localparam int col_we    = 1;
  localparam int col_size  = 2;
  localparam int col_sext  = 3;
  localparam int col_uoff  = 4;
  localparam int col_base  = 5;
  localparam int col_off   = 6;
  localparam int col_wdata = 7;
  localparam int col_rdata = 8;
  localparam int col_err   = 9;
  localparam int col_b2b   = 10;  // no idle cycles before this command

  logic        clk = 1'b0;
  logic        rst_n;
  logic        cmd_valid;
  lsu_cmd_t    cmd;
  logic        cmd_ready;
  logic        rsp_valid;
  lsu_rsp_t    rsp;

  logic [31:0] pat [nf*max_lines];
  int          exp_q [$];         // pattern lines of accepted commands in order
  logic [15:0] lfsr = 16'd28;
  int          n_lines;
  int          rsp_cnt = 0;
  int          err_cnt = 0;
  int          cycles = 0;
  int          cycle_limit = 100; // replaced once the patterns are counted
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_err_base = 0; // error count when the current test started

  lsu_top uut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .cmd_ready_o (cmd_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  always #half_per clk = ~clk;

  // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic next_gap(output int n);
    n = 0;
    repeat (2) begin  // two bits give 0 to 3 idle cycles
      lfsr = lfsr_step(lfsr);
      n    = n * 2 + int'(lfsr[0]);
    end
  endtask

  // word left in a slot that the pattern file did not reach
  function automatic logic [31:0] unread_mark(input int addr);
    return 32'hf000_0000 | 32'(addr);
  endfunction

  function automatic logic [31:0] field(input int line, input int col);
    return pat[line*nf + col];
  endfunction

  function automatic lsu_cmd_t make_cmd(input int line);
    lsu_cmd_t c;
    c.we       = pat[line*nf + col_we][0];
    c.size     = lsu_size_e'(pat[line*nf + col_size][1:0]);
    c.sign_ext = pat[line*nf + col_sext][0];
    c.use_off  = pat[line*nf + col_uoff][0];
    c.base     = field(line, col_base);
    c.offset   = field(line, col_off);
    c.wdata    = field(line, col_wdata);
    return c;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // entered on a falling edge and returns on the falling edge after acceptance
  task automatic send_cmd(input int line);
    logic accepted;
    accepted  = 1'b0;
    cmd       = make_cmd(line);
    cmd_valid = 1'b1;
    while (!accepted) begin
      #1;
      accepted = cmd_ready;  // settled well before the rising edge
      @(posedge clk);
      if (accepted) begin
        exp_q.push_back(line);
      end
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input int line);
    tests_run++;
    if (err_cnt == test_err_base) begin
      $display("test %0d ok", field(line, col_id));
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d mismatches", field(line, col_id),
               err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // registered outputs are steady at the falling edge
  always @(negedge clk) begin : rsp_check
    int idx;
    if (rst_n && rsp_valid) begin
      if (exp_q.size() == 0) begin
        $display("unexpected response at %0t ns while no command was pending", $time);
        err_cnt++;
      end else begin
        idx = exp_q.pop_front();
        check_val("rsp_o.rdata", field(idx, col_rdata), rsp.rdata);
        check_val("rsp_o.err", {31'b0, pat[idx*nf + col_err][0]}, {31'b0, rsp.err});
        check_val("rsp_o.we", {31'b0, pat[idx*nf + col_we][0]}, {31'b0, rsp.we});
        rsp_cnt++;
        if (idx == n_lines - 1 || field(idx + 1, col_id) != field(idx, col_id)) begin
          finish_test(idx);  // last response of this test id
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles with %0d of %0d responses received",
               cycles, rsp_cnt, n_lines);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int gap;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    for (int i = 0; i < nf*max_lines; i++) begin
      pat[i] = unread_mark(i);  // marks lines past the end of the file
    end
    $readmemh("lsu_patterns.txt", pat);
    n_lines = 0;
    while (n_lines < max_lines && pat[n_lines*nf] !== unread_mark(n_lines*nf)) begin
      n_lines++;
    end
    cycle_limit = 40 * n_lines + 100;
    if (n_lines == 0) begin
      $display("no pattern lines could be read from lsu_patterns.txt");
      err_cnt++;
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < n_lines; i++) begin
      if (pat[i*nf + col_b2b][0]) begin
        gap = 0;
      end else begin
        next_gap(gap);
      end
      if (gap > 0) begin
        cmd_valid = 1'b0;
        repeat (gap) @(negedge clk);
      end
      send_cmd(i);
    end
    cmd_valid = 1'b0;

    wait (rsp_cnt == n_lines);
    repeat (4) @(negedge clk);  // a stray extra response would show up here

    $display("%0d tests run, %0d failed, %0d responses checked, %0d errors",
             tests_run, tests_failed, rsp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- lsu_top.sv
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cmd_valid_i,
  input  lsu_pkg::lsu_cmd_t cmd_i,
  output logic              cmd_ready_o,
  output logic              rsp_valid_o,
  output lsu_pkg::lsu_rsp_t rsp_o
);
  import lsu_pkg::*;

  lsu_acc_t             acc;
  lsu_meta_t            meta;
  logic                 acc_valid, acc_ready;
  logic                 meta_valid;
  logic                 data_req, data_gnt, data_rvalid, data_we;
  logic [3:0]           data_be;
  logic [`LSU_XLEN-1:0] data_addr, data_wdata, data_rdata;

  lsu_agu u_agu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_ready_o (cmd_ready_o),
    .acc_valid_o (acc_valid),
    .acc_o       (acc),
    .acc_ready_i (acc_ready)
  );

  lsu_req_ctrl u_req_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .acc_valid_i   (acc_valid),
    .acc_i         (acc),
    .acc_ready_o   (acc_ready),
    .data_req_o    (data_req),
    .data_gnt_i    (data_gnt),
    .data_rvalid_i (data_rvalid),
    .data_addr_o   (data_addr),
    .data_we_o     (data_we),
    .data_be_o     (data_be),
    .data_wdata_o  (data_wdata),
    .meta_valid_o  (meta_valid),
    .meta_o        (meta)
  );

  lsu_data_mem u_data_mem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req),
    .data_gnt_o    (data_gnt),
    .data_rvalid_o (data_rvalid),
    .data_addr_i   (data_addr),
    .data_we_i     (data_we),
    .data_be_i     (data_be),
    .data_wdata_i  (data_wdata),
    .data_rdata_o  (data_rdata)
  );

  // rdata and meta arrive together on rvalid or an error pop
  lsu_rdata_align u_rdata_align (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .meta_valid_i (meta_valid),
    .meta_i       (meta),
    .data_rdata_i (data_rdata),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

endmodule

//--- lsu_data_mem.sv
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_data_mem #(
  parameter int unsigned depth = `LSU_MEM_WORDS
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 data_req_i,
  output logic                 data_gnt_o,
  output logic                 data_rvalid_o,
  input  logic [`LSU_XLEN-1:0] data_addr_i,
  input  logic                 data_we_i,
  input  logic [3:0]           data_be_i,
  input  logic [`LSU_XLEN-1:0] data_wdata_i,
  output logic [`LSU_XLEN-1:0] data_rdata_o
);

  localparam int unsigned idx_w      = (depth > 1) ? $clog2(depth) : 1;
  localparam logic [3:0]  wait_cycles = 4'(`LSU_MEM_WAIT);

  logic [`LSU_XLEN-1:0] mem_q [depth];
  logic [`LSU_XLEN-1:0] rdata_q;
  logic [idx_w-1:0]     idx;
  logic [3:0]           wait_q;   // cycles the current request has waited
  logic                 rvalid_q;

  initial begin
    for (int i = 0; i < depth; i++) begin
      mem_q[i] = '0;
    end
  end

  assign idx        = data_addr_i[2 +: idx_w]; // word index, low bits are the lane
  assign data_gnt_o = data_req_i && (wait_q == wait_cycles);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= data_gnt_o; // reads and writes both answer
      if (data_gnt_o) begin
        wait_q <= '0;         // next request waits again
      end else if (data_req_i) begin
        wait_q <= wait_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_gnt_o) begin
      rdata_q <= mem_q[idx];
      if (data_we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (data_be_i[b]) begin
            mem_q[idx][8*b +: 8] <= data_wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  assign data_rvalid_o = rvalid_q;
  assign data_rdata_o  = rdata_q;

  // out of range accesses are retired upstream and must never get here
  a_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_gnt_o |-> data_addr_i < `LSU_XLEN'(4 * depth))
    else $error("granted access beyond memory");

endmodule

//--- lsu_rdata_align.sv
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_rdata_align (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 meta_valid_i,
  input  lsu_pkg::lsu_meta_t   meta_i,
  input  logic [`LSU_XLEN-1:0] data_rdata_i,
  output logic                 rsp_valid_o,
  output lsu_pkg::lsu_rsp_t    rsp_o
);
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] mask_bits, masked, word, ext_word;
  logic [`LSU_XLEN-1:0] part_q;     // low half of a split load
  logic                 err_q;      // low half hit an error
  logic                 lo_pend_q;  // low half seen, high half due
  logic                 is_lo, is_hi, ext_bit, rsp_err;
  logic                 rsp_valid_q;
  lsu_rsp_t             rsp_d, rsp_q;

  assign is_lo = meta_i.phase == PhMisalignedLo;
  assign is_hi = meta_i.phase == PhMisalignedHi;

  assign mask_bits = {{8{meta_i.mask[3]}}, {8{meta_i.mask[2]}},
                      {8{meta_i.mask[1]}}, {8{meta_i.mask[0]}}};
  assign masked    = data_rdata_i & mask_bits;

  always_comb begin
    if (is_hi) begin
      // high bytes sit at the bottom of the next word, move them up past the low part
      word = (masked << {3'd4 - {1'b0, meta_i.shamt}, 3'b000}) | part_q;
    end else begin
      word = masked >> {meta_i.shamt, 3'b000};
    end
  end

  always_comb begin
    case (meta_i.size)
      SizeByte: begin
        ext_bit  = meta_i.sign_ext && word[7];
        ext_word = {{24{ext_bit}}, word[7:0]};
      end
      SizeHalf: begin
        ext_bit  = meta_i.sign_ext && word[15];
        ext_word = {{16{ext_bit}}, word[15:0]};
      end
      default: begin
        ext_bit  = 1'b0; // word needs no extension
        ext_word = word;
      end
    endcase
  end

  assign rsp_err     = meta_i.err || (is_hi && err_q);
  assign rsp_d.rdata = (rsp_err || meta_i.we) ? '0 : ext_word; // stores return zero
  assign rsp_d.we    = meta_i.we;
  assign rsp_d.err   = rsp_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      err_q       <= 1'b0;
      lo_pend_q   <= 1'b0;
    end else begin
      rsp_valid_q <= meta_valid_i && !is_lo; // low half never answers alone
      if (meta_valid_i) begin
        lo_pend_q <= is_lo;
        if (is_lo) begin
          err_q <= meta_i.err;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (meta_valid_i && is_lo) begin
      part_q <= word;
    end
    if (meta_valid_i && !is_lo) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  // split halves arrive back to back in the queue order set by the agu
  a_split_pair: assert property (@(posedge clk_i) disable iff (!rst_ni)
    meta_valid_i |-> (is_hi == lo_pend_q))
    else $error("split access halves out of order");

endmodule

//--- lsu_req_ctrl.sv
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_req_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 acc_valid_i,
  input  lsu_pkg::lsu_acc_t    acc_i,
  output logic                 acc_ready_o,
  output logic                 data_req_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  output logic [`LSU_XLEN-1:0] data_addr_o,
  output logic                 data_we_o,
  output logic [3:0]           data_be_o,
  output logic [`LSU_XLEN-1:0] data_wdata_o,
  output logic                 meta_valid_o,
  output lsu_pkg::lsu_meta_t   meta_o
);
  import lsu_pkg::*;

  localparam int unsigned max_outst = `LSU_MAX_OUTST;
  localparam int unsigned ptr_w     = (max_outst > 1) ? $clog2(max_outst) : 1;
  localparam int unsigned cnt_w     = $clog2(max_outst + 1);

  typedef enum logic [1:0] {
    Idle,    // queue empty, no request
    WaitGnt, // request up, holding for grant
    Drain    // entries waiting for rvalid or error pop
  } req_state_e;

  req_state_e       state_q, state_d;
  lsu_meta_t        queue_q [max_outst]; // one entry per access in flight
  lsu_meta_t        head;
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] cnt_q, cnt_d;
  logic             full, head_err;
  logic             req_fire, err_fire, push, pop;

  assign full = cnt_q == cnt_w'(max_outst);

  // once raised the request stays up until granted
  assign data_req_o = (state_q == WaitGnt) || (acc_valid_i && !acc_i.err && !full);
  assign req_fire   = data_req_o && data_gnt_i;
  assign err_fire   = acc_valid_i && acc_i.err && !full; // bypasses memory

  assign acc_ready_o = req_fire || err_fire;
  assign push        = acc_ready_o;

  // memory side comes straight from the held agu register
  assign data_addr_o  = acc_i.addr;
  assign data_we_o    = acc_i.we;
  assign data_be_o    = acc_i.be;
  assign data_wdata_o = acc_i.wdata;

  assign head     = queue_q[rd_ptr_q];
  assign head_err = (cnt_q != '0) && head.err; // error at head retires alone
  assign pop      = head_err || data_rvalid_i;

  assign meta_valid_o = pop;
  assign meta_o       = head;

  always_comb begin
    cnt_d = cnt_q;
    if (push && !pop) begin
      cnt_d = cnt_q + 1'b1;
    end else if (pop && !push) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle, Drain: begin
        if (data_req_o && !data_gnt_i) begin
          state_d = WaitGnt;
        end else begin
          state_d = (cnt_d == '0) ? Idle : Drain;
        end
      end
      WaitGnt: begin
        if (data_gnt_i) begin
          state_d = (cnt_d == '0) ? Idle : Drain;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= Idle;
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(max_outst - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(max_outst - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= acc_i.meta;
    end
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o
      && $stable({data_addr_o, data_we_o, data_be_o, data_wdata_o}))
    else $error("request fields changed before grant");

  // every rvalid must match a granted entry at the queue head
  a_rvalid_outst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |-> (cnt_q != '0) && !head.err)
    else $error("rvalid with no granted access outstanding");

  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> !$isunknown(data_addr_o))
    else $error("request with unknown address");

endmodule

//--- lsu_agu.sv
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_agu (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cmd_valid_i,
  input  lsu_pkg::lsu_cmd_t cmd_i,
  output logic              cmd_ready_o,
  output logic              acc_valid_o,
  output lsu_pkg::lsu_acc_t acc_o,
  input  logic              acc_ready_i
);
  import lsu_pkg::*;

  localparam logic [`LSU_XLEN-1:0] addr_limit = `LSU_XLEN'(4 * `LSU_MEM_WORDS);

  typedef enum logic {
    Single, // next command may enter
    Second  // high half of a split access still to go
  } agu_state_e;

  agu_state_e           state_q;
  logic                 acc_valid_q;
  lsu_acc_t             acc_q, hi_q;   // current access and parked high half
  lsu_acc_t             acc_lo, acc_hi;
  logic [`LSU_XLEN-1:0] addr, addr_lo, addr_hi;
  logic [`LSU_XLEN-1:0] wdata_rot;
  logic [1:0]           shamt;
  logic [3:0]           be_base;
  logic [7:0]           be_wide;       // enable before truncation to one word
  logic                 misaligned;
  logic                 cmd_fire, acc_fire;

  assign addr    = cmd_i.use_off ? cmd_i.base + cmd_i.offset : cmd_i.base;
  assign shamt   = addr[1:0];
  assign addr_lo = {addr[`LSU_XLEN-1:2], 2'b00};
  assign addr_hi = addr_lo + `LSU_XLEN'(4); // next word

  always_comb begin
    case (cmd_i.size)
      SizeByte: be_base = 4'b0001;
      SizeHalf: be_base = 4'b0011;
      default:  be_base = 4'b1111;
    endcase
  end
  assign be_wide = {4'b0000, be_base} << shamt; // upper nibble spills into next word

  // rotate store data left so each byte lands on its lane
  always_comb begin
    case (shamt)
      2'd1:    wdata_rot = {cmd_i.wdata[23:0], cmd_i.wdata[31:24]};
      2'd2:    wdata_rot = {cmd_i.wdata[15:0], cmd_i.wdata[31:16]};
      2'd3:    wdata_rot = {cmd_i.wdata[7:0],  cmd_i.wdata[31:8]};
      default: wdata_rot = cmd_i.wdata;
    endcase
  end

  assign misaligned = ((cmd_i.size == SizeWord) && (shamt != 2'd0))
                   || ((cmd_i.size == SizeHalf) && (shamt == 2'd3));

  always_comb begin
    acc_lo.addr          = addr_lo;
    acc_lo.we            = cmd_i.we;
    acc_lo.be            = be_wide[3:0];
    acc_lo.wdata         = wdata_rot;
    acc_lo.err           = addr >= addr_limit;
    acc_lo.meta.mask     = be_wide[3:0];
    acc_lo.meta.shamt    = shamt;
    acc_lo.meta.size     = cmd_i.size;
    acc_lo.meta.sign_ext = cmd_i.sign_ext;
    acc_lo.meta.we       = cmd_i.we;
    acc_lo.meta.phase    = misaligned ? PhMisalignedLo : PhRegular;
    acc_lo.meta.err      = acc_lo.err;

    // high half shares the rotated data, only its lanes differ
    acc_hi            = acc_lo;
    acc_hi.addr       = addr_hi;
    acc_hi.be         = be_wide[7:4];
    acc_hi.err        = acc_lo.err || (addr_hi >= addr_limit); // catches wrap too
    acc_hi.meta.mask  = be_wide[7:4];
    acc_hi.meta.phase = PhMisalignedHi;
    acc_hi.meta.err   = acc_hi.err;
  end

  assign cmd_ready_o = (state_q == Single) && (!acc_valid_q || acc_ready_i);
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;
  assign acc_fire    = acc_valid_q && acc_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Single;
      acc_valid_q <= 1'b0;
    end else if (cmd_fire) begin
      acc_valid_q <= 1'b1;
      state_q     <= misaligned ? Second : Single;
    end else if (acc_fire) begin
      if (state_q == Second) begin
        state_q <= Single; // valid stays up for the high half
      end else begin
        acc_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      acc_q <= acc_lo;
      hi_q  <= acc_hi;
    end else if (acc_fire && (state_q == Second)) begin
      acc_q <= hi_q;
    end
  end

  assign acc_valid_o = acc_valid_q;
  assign acc_o       = acc_q;

  // a stalled access must wait unchanged, req_ctrl drives memory straight from it
  a_acc_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_valid_o && !acc_ready_i |=> acc_valid_o && $stable(acc_o))
    else $error("access changed while stalled");

endmodule

//--- lsu_pkg.sv
`include "lsu_settings.svh"

package lsu_pkg;

  // access size, encoded like the ex stage data type
  typedef enum logic [1:0] {
    SizeWord = 2'd0,
    SizeHalf = 2'd1,
    SizeByte = 2'd2
  } lsu_size_e;

  // which part of a command a response belongs to
  typedef enum logic [1:0] {
    PhRegular      = 2'd0,  // whole command in one access
    PhMisalignedLo = 2'd1,  // first word of a split access
    PhMisalignedHi = 2'd2   // second word, completes the command
  } lsu_phase_e;

  typedef struct packed {
    logic                 we;       // store when set
    lsu_size_e            size;
    logic                 sign_ext; // sign extend loads
    logic                 use_off;  // add offset to base
    logic [`LSU_XLEN-1:0] base;
    logic [`LSU_XLEN-1:0] offset;
    logic [`LSU_XLEN-1:0] wdata;    // store data, lsb aligned
  } lsu_cmd_t;

  // what the response stage needs to rebuild one word
  typedef struct packed {
    logic [3:0] mask;
    logic [1:0] shamt;
    lsu_size_e  size;
    logic       sign_ext;
    logic       we;
    lsu_phase_e phase;
    logic       err;
  } lsu_meta_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;  // word aligned byte address
    logic                 we;
    logic [3:0]           be;
    logic [`LSU_XLEN-1:0] wdata; // already rotated into lanes
    logic                 err;   // out of range, never sent to memory
    lsu_meta_t            meta;
  } lsu_acc_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] rdata;
    logic                 we;
    logic                 err;
  } lsu_rsp_t;

endpackage

//--- lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data path and address width
`define LSU_XLEN 32

// data memory depth in words, byte range limit is 4x this
`define LSU_MEM_WORDS 256

// wait cycles between request rise and grant
`define LSU_MEM_WAIT 1

// accesses allowed between grant and rvalid
`define LSU_MAX_OUTST 2

`endif
